/* include/video_cfg.svh */
`ifndef VIDEO_CFG_SVH
`define VIDEO_CFG_SVH

// frame buffer geometry
`define FB_W        240
`define FB_H        160
`define FB_DEPTH    (`FB_W * `FB_H)
`define FB_AW       16

// BGR555 pixel, red in the low bits
`define COLOR_W     15

// 640x480 raster
`define H_ACTIVE    640
`define H_FP        16
`define H_SYNC      96
`define H_BP        48
`define H_TOTAL     (`H_ACTIVE + `H_FP + `H_SYNC + `H_BP)

`define V_ACTIVE    480
`define V_FP        10
`define V_SYNC      2
`define V_BP        33
`define V_TOTAL     (`V_ACTIVE + `V_FP + `V_SYNC + `V_BP)

// top-left of the doubled picture in active space
`define PIC_X0      80
`define PIC_Y0      80

`endif

/* design/video_pkg.sv */
`default_nettype none

`include "video_cfg.svh"

package video_pkg;

    // BGR555 to RGB444, keep top four bits per channel
    function automatic logic [11:0] to_vga_rgb(input logic [`COLOR_W-1:0] c);
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
        r = c[4:1];
        g = c[9:6];
        b = c[14:11];
        return {r, g, b};
    endfunction

endpackage : video_pkg

`default_nettype wire

/* design/scan_counter.sv */
`default_nettype none

module scan_counter #(
    parameter int WIDTH = 10,
    parameter int MAX   = 799
) (
    input  logic             clk,
    input  logic             rst_b,
    input  logic             en,
    input  logic             clear,
    output logic [WIDTH-1:0] count,
    output logic             last
);

    logic [WIDTH-1:0] count_nxt;

    assign last = (count == WIDTH'(MAX));

    // clear wins over enable
    always_comb begin
        if (clear) begin
            count_nxt = '0;
        end else if (!en) begin
            count_nxt = count;
        end else if (last) begin
            count_nxt = '0;
        end else begin
            count_nxt = count + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            count <= '0;
        end else begin
            count <= count_nxt;
        end
    end

endmodule : scan_counter

`default_nettype wire

/* design/pattern_renderer.sv */
`default_nettype none

`include "video_cfg.svh"

module pattern_renderer
    import video_pkg::*;
(
    input  logic               clk,
    input  logic               rst_b,
    input  logic               frame_start,
    input  logic [1:0]         mode,
    input  logic [`COLOR_W-1:0] fg_color,
    input  logic [`COLOR_W-1:0] bg_color,
    input  logic [7:0]         hofs,
    input  logic [7:0]         vofs,
    output logic               wr_en,
    output logic [`FB_AW-1:0]  wr_addr,
    output logic [`COLOR_W-1:0] wr_data
);

    logic                busy;
    logic [7:0]          col;
    logic [7:0]          row;
    logic                col_last;
    logic                row_last;
    logic [`FB_AW-1:0]   addr;
    logic [1:0]          mode_q;
    logic [`COLOR_W-1:0] fg_q;
    logic [`COLOR_W-1:0] bg_q;
    logic [7:0]          hofs_q;
    logic [7:0]          vofs_q;
    logic [7:0]          u;
    logic [7:0]          v;
    logic [7:0]          uv;

    scan_counter #(.WIDTH(8), .MAX(`FB_W - 1)) u_col (
        .clk   (clk),
        .rst_b (rst_b),
        .en    (busy),
        .clear (frame_start),
        .count (col),
        .last  (col_last)
    );

    // row steps at the end of each line
    scan_counter #(.WIDTH(8), .MAX(`FB_H - 1)) u_row (
        .clk   (clk),
        .rst_b (rst_b),
        .en    (busy && col_last),
        .clear (frame_start),
        .count (row),
        .last  (row_last)
    );

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            busy <= 1'b0;
            addr <= '0;
        end else if (frame_start) begin
            busy <= 1'b1;
            addr <= '0;
        end else if (busy) begin
            addr <= addr + 1'b1;
            if (col_last && row_last) begin
                busy <= 1'b0;
            end
        end
    end

    // pattern parameters held for a whole frame
    always_ff @(posedge clk) begin
        if (frame_start) begin
            mode_q <= mode;
            fg_q   <= fg_color;
            bg_q   <= bg_color;
            hofs_q <= hofs;
            vofs_q <= vofs;
        end
    end

    // scrolled coordinates wrap at 256
    assign u  = col + hofs_q;
    assign v  = row + vofs_q;
    assign uv = u ^ v;

    always_comb begin
        case (mode_q)
            2'd0:    wr_data = fg_q;
            2'd1:    wr_data = {u[4:0], u[4:0], u[4:0]};
            2'd2:    wr_data = (u[3] ^ v[3]) ? fg_q : bg_q;
            // xor spans red and the low green bits
            default: wr_data = {v[4:0], 2'b00, uv};
        endcase
    end

    assign wr_en   = busy;
    assign wr_addr = addr;

    // one frame of writes must finish before the next swap
    a_no_overlap : assert property (@(posedge clk) disable iff (!rst_b)
        frame_start |-> !busy)
        else $error("frame_start while renderer still busy");

endmodule : pattern_renderer

`default_nettype wire

/* design/frame_buffer.sv */
`default_nettype none

`include "video_cfg.svh"

module frame_buffer
    import video_pkg::*;
(
    input  logic                clk,
    input  logic                rst_b,
    input  logic                frame_start,
    input  logic                wr_en,
    input  logic [`FB_AW-1:0]   wr_addr,
    input  logic [`COLOR_W-1:0] wr_data,
    input  logic [`FB_AW-1:0]   rd_addr,
    output logic [`COLOR_W-1:0] rd_data
);

    localparam int NUM_BANKS = 2;

    logic                front;
    logic                wr_bank;
    logic                rd_sel;
    logic [`COLOR_W-1:0] bank_q [NUM_BANKS];

    // front bank flips at every raster frame start
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            front <= 1'b0;
        end else if (frame_start) begin
            front <= ~front;
        end
    end

    // bank that fed this cycle's read data
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            rd_sel <= 1'b0;
        end else begin
            rd_sel <= front;
        end
    end

    // renderer always fills the bank not on screen
    assign wr_bank = ~front;

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        logic [`COLOR_W-1:0] mem [`FB_DEPTH];

        always_ff @(posedge clk) begin
            if (wr_en && (wr_bank == 1'(b))) begin
                mem[wr_addr] <= wr_data;
            end
        end

        // both banks read every cycle, one is picked after the register
        always_ff @(posedge clk) begin
            bank_q[b] <= mem[rd_addr];
        end
    end

    assign rd_data = bank_q[rd_sel];

    a_wr_in_range : assert property (@(posedge clk) disable iff (!rst_b)
        wr_en |-> (wr_addr < `FB_AW'(`FB_DEPTH)))
        else $error("frame buffer write address out of range");

endmodule : frame_buffer

`default_nettype wire

/* design/vga_scanout.sv */
`default_nettype none

`include "video_cfg.svh"

module vga_scanout
    import video_pkg::*;
(
    input  logic                clk,
    input  logic                rst_b,
    input  logic [`COLOR_W-1:0] rd_data,
    output logic [`FB_AW-1:0]   rd_addr,
    output logic                frame_start,
    output logic [3:0]          vga_r,
    output logic [3:0]          vga_g,
    output logic [3:0]          vga_b,
    output logic                vga_hs,
    output logic                vga_vs,
    output logic                vga_de
);

    localparam int HS_BEGIN = `H_ACTIVE + `H_FP;
    localparam int VS_BEGIN = `V_ACTIVE + `V_FP;
    localparam int PIC_X1   = `PIC_X0 + 2 * `FB_W;
    localparam int PIC_Y1   = `PIC_Y0 + 2 * `FB_H;

    logic [9:0]  hcnt;
    logic [9:0]  vcnt;
    logic        h_last;
    logic        v_last;
    logic        active;
    logic        window;
    logic        hs;
    logic        vs;
    logic [9:0]  hx;
    logic [9:0]  vy;
    logic [7:0]  fx;
    logic [7:0]  fy;
    logic        de_d1;
    logic        win_d1;
    logic        hs_d1;
    logic        vs_d1;
    logic [11:0] rgb;

    scan_counter #(.WIDTH(10), .MAX(`H_TOTAL - 1)) u_hcnt (
        .clk   (clk),
        .rst_b (rst_b),
        .en    (1'b1),
        .clear (1'b0),
        .count (hcnt),
        .last  (h_last)
    );

    scan_counter #(.WIDTH(10), .MAX(`V_TOTAL - 1)) u_vcnt (
        .clk   (clk),
        .rst_b (rst_b),
        .en    (h_last),
        .clear (1'b0),
        .count (vcnt),
        .last  (v_last)
    );

    // stage 0, decode raster position
    assign active = (hcnt < 10'(`H_ACTIVE)) && (vcnt < 10'(`V_ACTIVE));
    assign window = (hcnt >= 10'(`PIC_X0)) && (hcnt < 10'(PIC_X1))
                 && (vcnt >= 10'(`PIC_Y0)) && (vcnt < 10'(PIC_Y1));
    assign hs = !((hcnt >= 10'(HS_BEGIN)) && (hcnt < 10'(HS_BEGIN + `H_SYNC)));
    assign vs = !((vcnt >= 10'(VS_BEGIN)) && (vcnt < 10'(VS_BEGIN + `V_SYNC)));

    // halve the picture-relative position for the doubled image
    assign hx = hcnt - 10'(`PIC_X0);
    assign vy = vcnt - 10'(`PIC_Y0);
    assign fx = hx[8:1];
    assign fy = vy[8:1];

    assign rd_addr = window ? (`FB_AW'(fy) * `FB_AW'(`FB_W) + `FB_AW'(fx)) : '0;

    // pulse lands while counters sit at 0,0
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            frame_start <= 1'b0;
        end else begin
            frame_start <= h_last && v_last;
        end
    end

    // stage 1, flags wait for memory read data
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            de_d1  <= 1'b0;
            win_d1 <= 1'b0;
            hs_d1  <= 1'b1;
            vs_d1  <= 1'b1;
        end else begin
            de_d1  <= active;
            win_d1 <= window;
            hs_d1  <= hs;
            vs_d1  <= vs;
        end
    end

    assign rgb = to_vga_rgb(rd_data);

    // stage 2, output registers, border forced black
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            vga_de <= 1'b0;
            vga_hs <= 1'b1;
            vga_vs <= 1'b1;
            vga_r  <= '0;
            vga_g  <= '0;
            vga_b  <= '0;
        end else begin
            vga_de <= de_d1;
            vga_hs <= hs_d1;
            vga_vs <= vs_d1;
            vga_r  <= win_d1 ? rgb[11:8] : 4'h0;
            vga_g  <= win_d1 ? rgb[7:4] : 4'h0;
            vga_b  <= win_d1 ? rgb[3:0] : 4'h0;
        end
    end

    // delayed flags must stay aligned through the pipeline
    a_de_outside_sync : assert property (@(posedge clk) disable iff (!rst_b)
        vga_de |-> (vga_hs && vga_vs))
        else $error("data enable during sync pulse");

endmodule : vga_scanout

`default_nettype wire

/* design/video_top.sv */
`default_nettype none

`include "video_cfg.svh"

module video_top
    import video_pkg::*;
(
    input  logic                clk,
    input  logic                rst_b,
    input  logic [1:0]          mode,
    input  logic [`COLOR_W-1:0] fg_color,
    input  logic [`COLOR_W-1:0] bg_color,
    input  logic [7:0]          hofs,
    input  logic [7:0]          vofs,
    output logic [3:0]          vga_r,
    output logic [3:0]          vga_g,
    output logic [3:0]          vga_b,
    output logic                vga_hs,
    output logic                vga_vs,
    output logic                vga_de
);

    logic                frame_start;
    logic                wr_en;
    logic [`FB_AW-1:0]   wr_addr;
    logic [`COLOR_W-1:0] wr_data;
    logic [`FB_AW-1:0]   rd_addr;
    logic [`COLOR_W-1:0] rd_data;

    // draws into the back bank
    pattern_renderer u_renderer (
        .clk         (clk),
        .rst_b       (rst_b),
        .frame_start (frame_start),
        .mode        (mode),
        .fg_color    (fg_color),
        .bg_color    (bg_color),
        .hofs        (hofs),
        .vofs        (vofs),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data)
    );

    frame_buffer u_fb (
        .clk         (clk),
        .rst_b       (rst_b),
        .frame_start (frame_start),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data)
    );

    // raster timing source, also paces the bank swap
    vga_scanout u_scanout (
        .clk         (clk),
        .rst_b       (rst_b),
        .rd_data     (rd_data),
        .rd_addr     (rd_addr),
        .frame_start (frame_start),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b),
        .vga_hs      (vga_hs),
        .vga_vs      (vga_vs),
        .vga_de      (vga_de)
    );

endmodule : video_top

`default_nettype wire

/* sim/video_tb.sv */
`default_nettype none

`include "video_cfg.svh"

module video_tb;

    localparam int NUM_FRAMES = 7;
    localparam int FRAME_CLKS = `H_TOTAL * `V_TOTAL;
    localparam int PIC_X1     = `PIC_X0 + 2 * `FB_W;
    localparam int PIC_Y1     = `PIC_Y0 + 2 * `FB_H;
    // about halfway through the renderer's pass over the back bank
    localparam int SCRAMBLE_LINE = `FB_DEPTH / `H_TOTAL / 2;

    logic                clk;
    logic                rst_b;
    logic [1:0]          mode;
    logic [`COLOR_W-1:0] fg_color;
    logic [`COLOR_W-1:0] bg_color;
    logic [7:0]          hofs;
    logic [7:0]          vofs;
    logic [3:0]          vga_r;
    logic [3:0]          vga_g;
    logic [3:0]          vga_b;
    logic                vga_hs;
    logic                vga_vs;
    logic                vga_de;

    integer seed;
    int     errors;
    int     cyc;
    int     frame_idx;
    int     frames_done;
    int     line_no;
    int     de_run;
    int     hs_low;
    int     vs_low;
    int     last_de_rise;
    int     cur_x;
    int     cur_y;
    logic   de_prev;
    logic   hs_prev;
    logic   vs_prev;
    logic   new_frame;
    logic [1:0] mode_base;

    // parameters the model expects the renderer to latch next
    logic [1:0]          p_mode;
    logic [`COLOR_W-1:0] p_fg;
    logic [`COLOR_W-1:0] p_bg;
    logic [7:0]          p_hofs;
    logic [7:0]          p_vofs;

    // per frame, the parameters latched at its start
    logic [1:0]          h_mode [NUM_FRAMES + 1];
    logic [`COLOR_W-1:0] h_fg   [NUM_FRAMES + 1];
    logic [`COLOR_W-1:0] h_bg   [NUM_FRAMES + 1];
    logic [7:0]          h_hofs [NUM_FRAMES + 1];
    logic [7:0]          h_vofs [NUM_FRAMES + 1];

    video_top u_dut (
        .clk      (clk),
        .rst_b    (rst_b),
        .mode     (mode),
        .fg_color (fg_color),
        .bg_color (bg_color),
        .hofs     (hofs),
        .vofs     (vofs),
        .vga_r    (vga_r),
        .vga_g    (vga_g),
        .vga_b    (vga_b),
        .vga_hs   (vga_hs),
        .vga_vs   (vga_vs),
        .vga_de   (vga_de)
    );

    always #4 clk = ~clk;

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s got %0h expected %0h (frame %0d, x %0d, y %0d)",
                     $time, what, got, exp, frame_idx, cur_x, cur_y);
            $display("Result: FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // BGR555 pattern value of frame pixel (c, r) with the parameters of frame f
    function automatic logic [14:0] pattern_pixel(input int f, input int c, input int r);
        logic [7:0] u;
        logic [7:0] v;
        logic [7:0] x;
        logic [4:0] red;
        logic [4:0] green;
        logic [4:0] blue;
        logic [14:0] px;
        u = 8'(c + int'(h_hofs[f]));
        v = 8'(r + int'(h_vofs[f]));
        x = u ^ v;
        case (h_mode[f])
            2'd0: px = h_fg[f];
            2'd1: px = {u[4:0], u[4:0], u[4:0]};
            2'd2: px = (u[3] != v[3]) ? h_fg[f] : h_bg[f];
            default: begin
                red   = x[4:0];
                green = {2'b00, x[7:5]};
                blue  = v[4:0];
                px    = {blue, green, red};
            end
        endcase
        return px;
    endfunction

    task automatic check_pixel(input int x, input int y);
        logic [14:0] px;
        if (x >= `PIC_X0 && x < PIC_X1 && y >= `PIC_Y0 && y < PIC_Y1) begin
            // banks hold real content from frame 2 on
            if (frame_idx >= 2) begin
                px = pattern_pixel(frame_idx - 1, (x - `PIC_X0) / 2, (y - `PIC_Y0) / 2);
                check_value("red", 32'(vga_r), 32'(px[4:1]));
                check_value("green", 32'(vga_g), 32'(px[9:6]));
                check_value("blue", 32'(vga_b), 32'(px[14:11]));
            end
        end else begin
            check_value("border rgb", 32'({vga_r, vga_g, vga_b}), 32'h0);
        end
    endtask

    task automatic check_idle_outputs();
        check_value("vga_hs", 32'(vga_hs), 32'h1);
        check_value("vga_vs", 32'(vga_vs), 32'h1);
        check_value("vga_de", 32'(vga_de), 32'h0);
        check_value("idle rgb", 32'({vga_r, vga_g, vga_b}), 32'h0);
    endtask

    // new values take effect at the next bank swap
    task automatic next_params();
        logic [31:0] r1;
        logic [31:0] r2;
        r1       = $random(seed);
        r2       = $random(seed);
        p_mode   = mode_base + 2'(frames_done);
        p_fg     = r1[14:0];
        p_bg     = r2[14:0];
        p_hofs   = r1[22:15];
        p_vofs   = r2[22:15];
        mode     = p_mode;
        fg_color = p_fg;
        bg_color = p_bg;
        hofs     = p_hofs;
        vofs     = p_vofs;
    endtask

    // mid-frame values differ from the latched ones in every field
    task automatic scramble_inputs();
        logic [31:0] r;
        r        = $random(seed);
        mode     = p_mode ^ (r[1:0] | 2'b01);
        fg_color = p_fg ^ (r[16:2] | 15'h1);
        bg_color = p_bg ^ (r[31:17] | 15'h1);
        hofs     = p_hofs ^ (r[9:2] | 8'h1);
        vofs     = p_vofs ^ (r[17:10] | 8'h1);
    endtask

    task automatic sample_cycle();
        cyc++;
        if (vga_de) begin
            if (!de_prev) begin
                if (new_frame) begin
                    // bank swap was two clocks before the first active pixel
                    frame_idx++;
                    line_no   = 0;
                    new_frame = 1'b0;
                    h_mode[frame_idx] = p_mode;
                    h_fg[frame_idx]   = p_fg;
                    h_bg[frame_idx]   = p_bg;
                    h_hofs[frame_idx] = p_hofs;
                    h_vofs[frame_idx] = p_vofs;
                end else begin
                    check_value("line period", 32'(cyc - last_de_rise), `H_TOTAL);
                end
                last_de_rise = cyc;
                de_run       = 0;
                // inputs change while the back bank is still being written
                if (line_no == SCRAMBLE_LINE) begin
                    scramble_inputs();
                end
            end
            cur_x = de_run;
            cur_y = line_no;
            check_pixel(de_run, line_no);
            de_run++;
        end else begin
            if (de_prev) begin
                check_value("active width", 32'(de_run), `H_ACTIVE);
                line_no++;
            end
            check_value("blank rgb", 32'({vga_r, vga_g, vga_b}), 32'h0);
        end

        if (!vga_hs) begin
            hs_low++;
        end else if (!hs_prev) begin
            check_value("hsync width", 32'(hs_low), `H_SYNC);
            hs_low = 0;
        end

        if (!vga_vs) begin
            vs_low++;
            if (vs_prev) begin
                check_value("active lines", 32'(line_no), `V_ACTIVE);
                frames_done++;
                new_frame = 1'b1;
                next_params();
            end
        end else if (!vs_prev) begin
            check_value("vsync width", 32'(vs_low), `V_SYNC * `H_TOTAL);
            vs_low = 0;
        end

        de_prev = vga_de;
        hs_prev = vga_hs;
        vs_prev = vga_vs;
    endtask

    initial begin
        int limit;
        int count;
        seed         = 32'hcfb1;
        errors       = 0;
        cyc          = 0;
        frame_idx    = -1;
        frames_done  = 0;
        line_no      = 0;
        de_run       = 0;
        hs_low       = 0;
        vs_low       = 0;
        last_de_rise = 0;
        cur_x        = 0;
        cur_y        = 0;
        de_prev      = 1'b0;
        hs_prev      = 1'b1;
        vs_prev      = 1'b1;
        new_frame    = 1'b1;
        clk          = 1'b0;
        rst_b        = 1'b0;
        mode_base    = 2'($random(seed));
        next_params();

        repeat (3) begin
            @(negedge clk);
            check_idle_outputs();
        end
        rst_b = 1'b1;
        @(negedge clk);
        check_idle_outputs();

        limit = (NUM_FRAMES + 1) * FRAME_CLKS;
        count = 0;
        while (frames_done < NUM_FRAMES && count < limit) begin
            @(negedge clk);
            sample_cycle();
            count++;
        end

        if (frames_done < NUM_FRAMES) begin
            $display("Timeout: only %0d of %0d frames seen in %0d clocks",
                     frames_done, NUM_FRAMES, limit);
            $display("Result: FAILED");
            $fatal(1, "raster stopped before the last frame");
        end else if (errors == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("Result: FAILED");
            $finish;
        end
    end

endmodule : video_tb

`default_nettype wire

/* verilog.f */
+incdir+include
design/video_pkg.sv
design/scan_counter.sv
design/pattern_renderer.sv
design/frame_buffer.sv
design/vga_scanout.sv
design/video_top.sv
sim/video_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module video_tb -f verilog.f -o video_tb_sim

output=$(./obj_dir/video_tb_sim) || true
echo "$output"

if grep -q "Result: PASSED" <<< "$output"; then
    exit 0
fi
exit 1
